/* hw/amigaMapPkg.sv */
// Address map constants for the CPU bus decode; fields index address bits 31..12 only
package amigaMapPkg;

  //////////////////////////////////////////////////////////////
  // Field widths
  //////////////////////////////////////////////////////////////

  // Cycle address carries CPU bits 31..12
  localparam int addrWidth = 20;
  // Bridge register base sits on bits 23..16
  localparam int bridgeBaseWidth = 8;
  // IDE base sits on bits 23..17, a 128k window
  localparam int ideBaseWidth = 7;
  // Prometheus base sits on bits 31..29
  localparam int proBaseWidth = 3;

  //////////////////////////////////////////////////////////////
  // Fixed map
  //////////////////////////////////////////////////////////////

  // Bits 31..24 all zero means the 24-bit space
  localparam logic [7:0] z2Top = 8'h00;

  // Pages on bits 23..16
  localparam logic [7:0] ciaPage = 8'hBF;
  localparam logic [7:0] regPage = 8'hDF;
  localparam logic [7:0] autoconfigPage = 8'hE8;

  // RTC at $DC0000..$DDFFFF, bits 23..17
  localparam logic [6:0] rtcBlock = 7'h6E;

  // 512k blocks on bits 23..19
  localparam logic [4:0] hiRomBlock = 5'h1F;
  localparam logic [4:0] flashBlock0 = 5'h1C;
  localparam logic [4:0] flashBlock1 = 5'h1E;

  // Chip RAM is the bottom 2M, bits 23..21
  localparam logic [2:0] chipRamBlock = 3'b000;

  //////////////////////////////////////////////////////////////
  // Transfer type and modifier codes
  //////////////////////////////////////////////////////////////

  localparam logic [1:0] ttAlternate = 2'b10;
  localparam logic [1:0] ttAcknowledge = 2'b11;
  // Modifier that selects config type 1 in alternate cycles
  localparam logic [2:0] tmConfig1 = 3'b011;

endpackage

/* hw/pciBridgePkg.sv */
// Bridge request encoding and queue sizing; queueDepth must equal 2**queuePtrWidth
package pciBridgePkg;

  // Access types as seen by the bridge
  localparam logic [1:0] accessConfig0 = 2'b00;
  localparam logic [1:0] accessConfig1 = 2'b01;
  localparam logic [1:0] accessMemory = 2'b10;
  localparam logic [1:0] accessIo = 2'b11;

  //////////////////////////////////////////////////////////////
  // Request queue
  //////////////////////////////////////////////////////////////

  localparam int queueDepth = 4;
  localparam int queuePtrWidth = 2;

  // Address, then type, then direction
  localparam int requestWidth = amigaMapPkg::addrWidth + 2 + 1;

  //////////////////////////////////////////////////////////////
  // Prometheus window offsets
  //////////////////////////////////////////////////////////////

  // Config windows on bits 28..20
  localparam logic [8:0] proConf0Offset = 9'h1FC;
  localparam logic [8:0] proConf1Offset = 9'h1FD;
  // I/O window on bits 28..21
  localparam logic [7:0] proIoOffset = 8'hFF;

endpackage

/* hw/cpuCycleCapture.sv */
// Start strobes must be at least two clocks apart; fields are only valid while cycleActive is high
`timescale 1ns/1ps

module cpuCycleCapture (
  input  logic CLK40,
  input  logic RESETn,
  input  logic cycleStartn,
  input  logic cycleEndn,
  input  logic [amigaMapPkg::addrWidth-1:0] address,
  input  logic [1:0] tt,
  input  logic [2:0] tm,
  input  logic rnw,
  output logic [amigaMapPkg::addrWidth-1:0] cycleAddr,
  output logic [1:0] cycleTt,
  output logic [2:0] cycleTm,
  output logic cycleRnw,
  output logic cycleActive,
  output logic cycleNew
);

  // Cycle fields, loaded only on a start
  always_ff @(posedge CLK40) begin
    if (!cycleStartn) begin
      cycleAddr <= address;
      cycleTt <= tt;
      cycleTm <= tm;
      cycleRnw <= rnw;
    end
  end

  // Active level and the new-cycle pulse
  // start wins over an end in the same clock
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      cycleActive <= 1'b0;
      cycleNew <= 1'b0;
    end else begin
      cycleNew <= !cycleStartn;
      if (!cycleStartn) begin
        cycleActive <= 1'b1;
      end else if (!cycleEndn) begin
        cycleActive <= 1'b0;
      end
    end
  end

  // Back to back starts would merge two cycles into one decode window
  newIsSinglePulse: assert property (
    @(posedge CLK40) disable iff (!RESETn) cycleNew |=> !cycleNew
  );

endmodule

/* hw/addressDecode.sv */
// Outputs are combinational from the held cycle; base inputs must be stable while configured is set
`timescale 1ns/1ps

module addressDecode (
  input  logic CLK40,
  input  logic RESETn,
  input  logic [amigaMapPkg::addrWidth-1:0] cycleAddr,
  input  logic [1:0] cycleTt,
  input  logic [2:0] cycleTm,
  input  logic cycleRnw,
  input  logic cycleActive,
  input  logic cycleNew,
  input  logic ovl,
  input  logic ciaEnable,
  input  logic configured,
  input  logic [amigaMapPkg::bridgeBaseWidth-1:0] bridgeBase,
  input  logic [amigaMapPkg::ideBaseWidth-1:0] ideBase,
  input  logic [amigaMapPkg::proBaseWidth-1:0] proBase,
  output logic romEn,
  output logic ciaSpace,
  output logic ciaCs0n,
  output logic ciaCs1n,
  output logic ramSpacen,
  output logic regSpacen,
  output logic rtcEnn,
  output logic autoconfigSpace,
  output logic flashSpace0,
  output logic flashSpace1,
  output logic autovector,
  output logic ataSpace,
  output logic ataEnn,
  output logic pcs0,
  output logic pcs1,
  output logic scs0,
  output logic scs1,
  output logic bregEnn,
  output logic bproEnn,
  output logic pushReq,
  output logic [amigaMapPkg::addrWidth-1:0] pushAddr,
  output logic [1:0] pushType,
  output logic pushRnw
);

  import amigaMapPkg::*;
  import pciBridgePkg::*;

  // CPU address bit n is cycleAddr[n-12]
  logic [7:0] aTop;
  logic [7:0] aPage;
  logic z2Space;
  logic ideCs0;
  logic ideCs1;
  logic ataEn;
  logic bregHit;
  logic proHit;

  assign aTop = cycleAddr[19:12];
  assign aPage = cycleAddr[11:4];
  assign z2Space = cycleActive && (aTop == z2Top);

  //////////////////////////////////////////////////////////////
  // Fixed 24-bit map
  //////////////////////////////////////////////////////////////

  // Low ROM only under overlay, the high copy always answers
  assign romEn = z2Space && ((ovl && cycleAddr[11:7] == 5'b00000) ||
                             cycleAddr[11:7] == hiRomBlock);

  assign ciaSpace = z2Space && (aPage == ciaPage);
  // Even CIA on A12 low, odd CIA on A13 low
  assign ciaCs0n = !(cycleActive && ciaEnable && !cycleAddr[0]);
  assign ciaCs1n = !(cycleActive && ciaEnable && !cycleAddr[1]);

  // Chip RAM hidden while ROM overlays the bottom
  assign ramSpacen = !(z2Space && !ovl && cycleAddr[11:9] == chipRamBlock);
  assign regSpacen = !(z2Space && aPage == regPage);
  assign rtcEnn = !(z2Space && cycleAddr[11:5] == rtcBlock);
  assign autoconfigSpace = z2Space && (aPage == autoconfigPage);
  assign flashSpace0 = z2Space && (cycleAddr[11:7] == flashBlock0);
  assign flashSpace1 = z2Space && (cycleAddr[11:7] == flashBlock1);

  // Interrupt acknowledge at $FFFFxxxx, every level autovectored
  assign autovector = cycleActive && (cycleTt == ttAcknowledge) &&
                      (cycleAddr[19:4] == 16'hFFFF);

  //////////////////////////////////////////////////////////////
  // IDE
  //////////////////////////////////////////////////////////////

  assign ataSpace = z2Space && configured && (cycleAddr[11:5] == ideBase);

  // Task file on A12 set, control block on A13 set, A16 and A15 clear
  assign ideCs0 = !cycleAddr[4] && !cycleAddr[3] && !cycleAddr[1] && cycleAddr[0];
  assign ideCs1 = !cycleAddr[4] && !cycleAddr[3] && cycleAddr[1] && !cycleAddr[0];
  // A14 picks primary or secondary channel
  assign pcs0 = ataSpace && ideCs0 && !cycleAddr[2];
  assign pcs1 = ataSpace && ideCs0 && cycleAddr[2];
  assign scs0 = ataSpace && ideCs1 && !cycleAddr[2];
  assign scs1 = ataSpace && ideCs1 && cycleAddr[2];

  // Window serves the boot ROM until the first write, then the drive
  assign ataEnn = !(ataSpace && ataEn);

  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      ataEn <= 1'b0;
    end else if (cycleNew && ataSpace && !cycleRnw) begin
      ataEn <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////
  // PCI bridge
  //////////////////////////////////////////////////////////////

  // Register block is a 64k device in the 24-bit space
  assign bregHit = z2Space && configured && (aPage == bridgeBase);
  // Prometheus window lives above the 24-bit space
  assign proHit = cycleActive && configured && (aTop != z2Top) &&
                  (cycleAddr[19:17] == proBase);
  assign bregEnn = !bregHit;
  assign bproEnn = !proHit;

  // Prometheus offsets pick the type; register hits use TT and TM
  always_comb begin
    pushType = accessMemory;
    if (proHit) begin
      if (cycleAddr[16:8] == proConf0Offset) begin
        pushType = accessConfig0;
      end else if (cycleAddr[16:8] == proConf1Offset) begin
        pushType = accessConfig1;
      end else if (cycleAddr[16:9] == proIoOffset) begin
        pushType = accessIo;
      end
    end else if (cycleTt == ttAlternate) begin
      pushType = (cycleTm == tmConfig1) ? accessConfig1 : accessConfig0;
    end
  end

  // One push per bridge cycle, on its first decoded clock
  assign pushReq = cycleNew && (bregHit || proHit);
  assign pushAddr = cycleAddr;
  assign pushRnw = cycleRnw;

endmodule

/* hw/bridgeQueue.sv */
// Pushing while queueFull is high is illegal; head outputs are undefined while queueEmpty is high
`timescale 1ns/1ps

module bridgeQueue (
  input  logic CLK40,
  input  logic RESETn,
  input  logic pushReq,
  input  logic [amigaMapPkg::addrWidth-1:0] pushAddr,
  input  logic [1:0] pushType,
  input  logic pushRnw,
  input  logic pop,
  output logic [amigaMapPkg::addrWidth-1:0] headAddr,
  output logic [1:0] headType,
  output logic headRnw,
  output logic queueEmpty,
  output logic queueFull
);

  import pciBridgePkg::*;

  logic [requestWidth-1:0] entries [queueDepth];
  logic [queuePtrWidth-1:0] wrPtr;
  logic [queuePtrWidth-1:0] rdPtr;
  // One extra bit so a full queue is distinct from empty
  logic [queuePtrWidth:0] count;

  // Storage, no reset
  always_ff @(posedge CLK40) begin
    if (pushReq) begin
      entries[wrPtr] <= {pushAddr, pushType, pushRnw};
    end
  end

  // Pointers wrap naturally at the depth
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (pushReq) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (pushReq && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !pushReq) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head is read straight from storage
  assign {headAddr, headType, headRnw} = entries[rdPtr];

  assign queueEmpty = (count == '0);
  assign queueFull = (count == queueDepth);

  noPushWhenFull: assert property (
    @(posedge CLK40) disable iff (!RESETn) !(pushReq && queueFull)
  );

  noPopWhenEmpty: assert property (
    @(posedge CLK40) disable iff (!RESETn) !(pop && queueEmpty)
  );

endmodule

/* hw/pciRequestIssuer.sv */
// One access per popped request; the bridge must accept a start whenever pciReady was high
`timescale 1ns/1ps

module pciRequestIssuer (
  input  logic CLK40,
  input  logic RESETn,
  input  logic [amigaMapPkg::addrWidth-1:0] headAddr,
  input  logic [1:0] headType,
  input  logic headRnw,
  input  logic queueEmpty,
  input  logic pciReady,
  output logic pop,
  output logic pciStart,
  output logic [amigaMapPkg::addrWidth-1:0] pciAddr,
  output logic [1:0] pciAccessType,
  output logic pciRnw
);

  // Take the head as soon as the bridge can accept it
  assign pop = !queueEmpty && pciReady;

  // Held access fields, loaded with each pop
  always_ff @(posedge CLK40) begin
    if (pop) begin
      pciAddr <= headAddr;
      pciAccessType <= headType;
      pciRnw <= headRnw;
    end
  end

  // Start strobe lines up with the freshly loaded fields
  always_ff @(posedge CLK40) begin
    if (!RESETn) begin
      pciStart <= 1'b0;
    end else begin
      pciStart <= pop;
    end
  end

endmodule

/* hw/amigaPciDecodeTop.sv */
// Decode is valid one clock after the start strobe; hold off bridge cycles while queueFull is high
`timescale 1ns/1ps

module amigaPciDecodeTop (
  input  logic CLK40,
  input  logic RESETn,
  input  logic cycleStartn,
  input  logic cycleEndn,
  input  logic [amigaMapPkg::addrWidth-1:0] address,
  input  logic [1:0] tt,
  input  logic [2:0] tm,
  input  logic rnw,
  input  logic ovl,
  input  logic ciaEnable,
  input  logic configured,
  input  logic [amigaMapPkg::bridgeBaseWidth-1:0] bridgeBase,
  input  logic [amigaMapPkg::ideBaseWidth-1:0] ideBase,
  input  logic [amigaMapPkg::proBaseWidth-1:0] proBase,
  input  logic pciReady,
  output logic romEn,
  output logic ciaSpace,
  output logic ciaCs0n,
  output logic ciaCs1n,
  output logic ramSpacen,
  output logic regSpacen,
  output logic rtcEnn,
  output logic autoconfigSpace,
  output logic flashSpace0,
  output logic flashSpace1,
  output logic autovector,
  output logic ataSpace,
  output logic ataEnn,
  output logic pcs0,
  output logic pcs1,
  output logic scs0,
  output logic scs1,
  output logic bregEnn,
  output logic bproEnn,
  output logic queueFull,
  output logic pciStart,
  output logic [amigaMapPkg::addrWidth-1:0] pciAddr,
  output logic [1:0] pciAccessType,
  output logic pciRnw
);

  import amigaMapPkg::*;

  // Held CPU cycle
  logic [addrWidth-1:0] cycleAddr;
  logic [1:0] cycleTt;
  logic [2:0] cycleTm;
  logic cycleRnw;
  logic cycleActive;
  logic cycleNew;

  // Decode to queue
  logic pushReq;
  logic [addrWidth-1:0] pushAddr;
  logic [1:0] pushType;
  logic pushRnw;

  // Queue to issuer
  logic [addrWidth-1:0] headAddr;
  logic [1:0] headType;
  logic headRnw;
  logic queueEmpty;
  logic pop;

  // Port names match across the hierarchy
  cpuCycleCapture capture_i (.*);
  addressDecode decode_i (.*);
  bridgeQueue queue_i (.*);
  pciRequestIssuer issuer_i (.*);

endmodule

/* bench/amigaPciDecodeTb.sv */
// Random decode testbench; bases are only changed while configured is low, never pushes into a full queue
`timescale 1ns/1ps

module amigaPciDecodeTb;

  import amigaMapPkg::*;
  import pciBridgePkg::*;

  logic CLK40;
  logic RESETn;
  logic cycleStartn;
  logic cycleEndn;
  logic [addrWidth-1:0] address;
  logic [1:0] tt;
  logic [2:0] tm;
  logic rnw;
  logic ovl;
  logic ciaEnable;
  logic configured;
  logic [bridgeBaseWidth-1:0] bridgeBase;
  logic [ideBaseWidth-1:0] ideBase;
  logic [proBaseWidth-1:0] proBase;
  logic pciReady;
  logic romEn;
  logic ciaSpace;
  logic ciaCs0n;
  logic ciaCs1n;
  logic ramSpacen;
  logic regSpacen;
  logic rtcEnn;
  logic autoconfigSpace;
  logic flashSpace0;
  logic flashSpace1;
  logic autovector;
  logic ataSpace;
  logic ataEnn;
  logic pcs0;
  logic pcs1;
  logic scs0;
  logic scs1;
  logic bregEnn;
  logic bproEnn;
  logic queueFull;
  logic pciStart;
  logic pciRnw;
  logic [addrWidth-1:0] pciAddr;
  logic [1:0] pciAccessType;

  // Model state
  logic [15:0] lfsr;
  logic ataSticky;
  logic holdOff;
  logic [requestWidth-1:0] expQ [$];
  logic [requestWidth-1:0] issued;
  logic [31:0] r;
  int i;

  // Bit i of the decode vector
  string decodeNames [19] = '{"bproEnn", "bregEnn", "scs1", "scs0", "pcs1", "pcs0", "ataEnn",
    "ataSpace", "autovector", "flashSpace1", "flashSpace0", "autoconfigSpace", "rtcEnn",
    "regSpacen", "ramSpacen", "ciaCs1n", "ciaCs0n", "ciaSpace", "romEn"};

  amigaPciDecodeTop dut_i (.*);

  initial CLK40 = 1'b0;
  always #2 CLK40 = !CLK40;

  ////////////////////////////////////////////////////////////
  // Reporting and random bits
  ////////////////////////////////////////////////////////////

  task automatic failRun(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] want);
    assert (got === want) else failRun($sformatf("FAILED %s got %h expected %h", name, got, want));
  endtask

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsrStep(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model of the map
  ////////////////////////////////////////////////////////////

  // Full CPU address rebuilt so the map reads in CPU bit numbers
  function automatic logic [18:0] expectDecode(input logic [19:0] ca, input logic [1:0] ctt,
                                               input logic ataOn);
    logic [31:0] a;
    logic z2;
    logic ide;
    logic cs0;
    logic cs1;
    a = {ca, 12'h000};
    z2 = (a[31:24] == z2Top);
    ide = z2 && configured && (a[23:17] == ideBase);
    // IDE table with A16 A15 clear, A13 A12 = 01 task file, 10 control block
    cs0 = ide && (a[16:15] == 2'b00) && (a[13:12] == 2'b01);
    cs1 = ide && (a[16:15] == 2'b00) && (a[13:12] == 2'b10);
    return {z2 && ((ovl && a[23:19] == 5'h00) || a[23:19] == hiRomBlock),
            z2 && a[23:16] == ciaPage,
            !(ciaEnable && !a[12]),
            !(ciaEnable && !a[13]),
            !(z2 && !ovl && a[23:21] == chipRamBlock),
            !(z2 && a[23:16] == regPage),
            !(z2 && a[23:17] == rtcBlock),
            z2 && a[23:16] == autoconfigPage,
            z2 && a[23:19] == flashBlock0,
            z2 && a[23:19] == flashBlock1,
            ctt == ttAcknowledge && a[31:16] == 16'hFFFF,
            ide,
            !(ide && ataOn),
            cs0 && !a[14],
            cs0 && a[14],
            cs1 && !a[14],
            cs1 && a[14],
            !(z2 && configured && a[23:16] == bridgeBase),
            !(!z2 && configured && a[31:29] == proBase)};
  endfunction

  function automatic logic bridgeHit(input logic [19:0] ca);
    return configured && ((ca[19:12] == z2Top && ca[11:4] == bridgeBase) ||
                          (ca[19:12] != z2Top && ca[19:17] == proBase));
  endfunction

  function automatic logic [1:0] accessType(input logic [19:0] ca, input logic [1:0] ctt,
                                            input logic [2:0] ctm);
    logic [31:0] a;
    a = {ca, 12'h000};
    // Prometheus window, offset picks the type
    if (a[31:24] != z2Top) begin
      return (a[28:20] == proConf0Offset) ? accessConfig0 :
             (a[28:20] == proConf1Offset) ? accessConfig1 :
             (a[28:21] == proIoOffset) ? accessIo : accessMemory;
    end
    return (ctt == ttAlternate) ? ((ctm == tmConfig1) ? accessConfig1 : accessConfig0)
                                : accessMemory;
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic compareDecode(input logic [18:0] e);
    logic [18:0] a;
    a = {romEn, ciaSpace, ciaCs0n, ciaCs1n, ramSpacen, regSpacen, rtcEnn, autoconfigSpace,
         flashSpace0, flashSpace1, autovector, ataSpace, ataEnn, pcs0, pcs1, scs0, scs1,
         bregEnn, bproEnn};
    for (int k = 0; k < 19; k++) begin
      checkVal(decodeNames[k], a[k], e[k]);
    end
  endtask

  // One CPU cycle, two clocks long, decode checked one clock after start
  task automatic runCycle(input logic [19:0] ca, input logic [1:0] ctt, input logic [2:0] ctm,
                          input logic crnw);
    logic [18:0] e;
    int n;
    n = 0;
    // Bridge cycles wait for room in the queue
    while (bridgeHit(ca) && queueFull) begin
      pciReady = 1'b1;
      @(posedge CLK40);
      #0.5;
      n++;
      assert (n < 50) else failRun("queue stayed full with pciReady high");
    end
    address = ca;
    tt = ctt;
    tm = ctm;
    rnw = crnw;
    cycleStartn = 1'b0;
    @(posedge CLK40);
    #0.5;
    cycleStartn = 1'b1;
    cycleEndn = 1'b0;
    e = expectDecode(ca, ctt, ataSticky);
    compareDecode(e);
    if (bridgeHit(ca)) begin
      expQ.push_back({ca, accessType(ca, ctt, ctm), crnw});
    end
    // First IDE write hands the window to the drive
    if (e[7] && !crnw) begin
      ataSticky = 1'b1;
    end
    @(posedge CLK40);
    #0.5;
    cycleEndn = 1'b1;
  endtask

  // Addresses biased toward the map, a quarter fully random
  task automatic pickCycle(output logic [19:0] ca, output logic [1:0] ctt,
                           output logic [2:0] ctm, output logic crnw);
    logic [31:0] v;
    logic [31:0] sel;
    takeBits(4, sel);
    takeBits(20, v);
    ca = v[19:0];
    takeBits(6, v);
    ctt = v[1:0];
    ctm = v[4:2];
    crnw = v[5];
    if (sel < 8 || sel == 9 || sel == 10) begin
      ca[19:12] = z2Top;
    end
    case (sel)
      0: ca[11:7] = 5'h00;
      1: ca[11:7] = hiRomBlock;
      2: ca[11:4] = ciaPage;
      3: ca[11:4] = regPage;
      4: ca[11:5] = rtcBlock;
      5: ca[11:4] = autoconfigPage;
      6: ca[11:7] = flashBlock0;
      7: ca[11:7] = flashBlock1;
      8: begin
        ca[19:4] = 16'hFFFF;
        ctt = ttAcknowledge;
      end
      9: ca[11:5] = ideBase;
      10: ca[11:4] = bridgeBase;
      11: begin
        ca[19:17] = proBase;
        takeBits(2, v);
        if (v[1:0] == 2'd0) begin
          ca[16:8] = proConf0Offset;
        end else if (v[1:0] == 2'd1) begin
          ca[16:8] = proConf1Offset;
        end else if (v[1:0] == 2'd2) begin
          ca[16:9] = proIoOffset;
        end
      end
      default: ;
    endcase
  endtask

  task automatic randomCycles(input int count);
    logic [31:0] v;
    logic [19:0] ca;
    logic [1:0] ctt;
    logic [2:0] ctm;
    logic crnw;
    for (int k = 0; k < count; k++) begin
      takeBits(3, v);
      ovl = v[0];
      pciReady = v[1];
      ciaEnable = v[2];
      pickCycle(ca, ctt, ctm, crnw);
      runCycle(ca, ctt, ctm, crnw);
    end
  endtask

  task automatic drainQueue();
    int n;
    n = 0;
    pciReady = 1'b1;
    while (expQ.size() != 0) begin
      @(posedge CLK40);
      #0.5;
      n++;
      assert (n < 100) else failRun("pending bridge requests were never issued");
    end
  endtask

  // Every start must match the oldest expected request
  always @(posedge CLK40) begin
    #1;
    if (RESETn && pciStart) begin
      assert (!holdOff) else failRun("pciStart occurred while pciReady was held low");
      assert (expQ.size() > 0) else failRun("pciStart occurred with no request pending");
      issued = expQ.pop_front();
      checkVal("pciAddr", pciAddr, issued[requestWidth-1:3]);
      checkVal("pciAccessType", pciAccessType, issued[2:1]);
      checkVal("pciRnw", pciRnw, issued[0]);
    end
  end

  initial begin
    lfsr = 16'd1438;
    ataSticky = 1'b0;
    holdOff = 1'b0;
    RESETn = 1'b0;
    cycleStartn = 1'b1;
    cycleEndn = 1'b1;
    address = '0;
    tt = 2'b00;
    tm = 3'b000;
    rnw = 1'b1;
    ovl = 1'b1;
    ciaEnable = 1'b1;
    configured = 1'b0;
    bridgeBase = '0;
    ideBase = '0;
    proBase = '0;
    pciReady = 1'b0;
    repeat (4) @(posedge CLK40);
    #0.5;
    RESETn = 1'b1;
    // Idle state, selects high and spaces low
    compareDecode({7'b0011111, 5'b00000, 1'b1, 4'b0000, 2'b11});
    checkVal("pciStart", pciStart, 0);
    checkVal("queueFull", queueFull, 0);
    // Unconfigured, bridge and IDE must stay quiet
    randomCycles(150);
    takeBits(18, r);
    bridgeBase = r[7:0];
    ideBase = r[14:8];
    proBase = (r[17:15] == 3'd0) ? 3'd5 : r[17:15];
    configured = 1'b1;
    // IDE reads see the boot ROM until the first write
    for (i = 0; i < 8; i++) begin
      takeBits(5, r);
      runCycle({z2Top, ideBase, r[4:0]}, 2'b00, 3'b000, 1'b1);
    end
    takeBits(5, r);
    runCycle({z2Top, ideBase, r[4:0]}, 2'b00, 3'b000, 1'b0);
    for (i = 0; i < 8; i++) begin
      takeBits(5, r);
      runCycle({z2Top, ideBase, r[4:0]}, 2'b00, 3'b000, 1'b1);
    end
    randomCycles(300);
    drainQueue();
    // Back-pressure with the bridge stalled
    pciReady = 1'b0;
    @(posedge CLK40);
    #0.5;
    holdOff = 1'b1;
    for (i = 0; i < queueDepth; i++) begin
      takeBits(10, r);
      runCycle({z2Top, bridgeBase, r[3:0]}, r[5:4], r[8:6], r[9]);
      checkVal("queueFull", queueFull, i == queueDepth - 1);
    end
    repeat (4) @(posedge CLK40);
    #0.5;
    checkVal("queueFull", queueFull, 1);
    holdOff = 1'b0;
    drainQueue();
    checkVal("queueFull", queueFull, 0);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* amigaPciDecode.f */
hw/amigaMapPkg.sv
hw/pciBridgePkg.sv
hw/cpuCycleCapture.sv
hw/addressDecode.sv
hw/bridgeQueue.sv
hw/pciRequestIssuer.sv
hw/amigaPciDecodeTop.sv
bench/amigaPciDecodeTb.sv

/* Bender.yml */
package:
  name: amigaPciDecode

sources:
  # Packages first, the RTL depends on them
  - hw/amigaMapPkg.sv
  - hw/pciBridgePkg.sv
  - hw/cpuCycleCapture.sv
  - hw/addressDecode.sv
  - hw/bridgeQueue.sv
  - hw/pciRequestIssuer.sv
  - hw/amigaPciDecodeTop.sv
  - target: test
    files:
      - bench/amigaPciDecodeTb.sv
